//--- logic/tp84_timing_pkg.sv
`default_nettype none

package tp84_timing_pkg;

	// ==================================================
	// Beam geometry
	// ==================================================

	// Pixels per line and lines per frame
	localparam int H_TOTAL_DEF = 384;
	localparam int V_TOTAL_DEF = 264;
	// 49.152 MHz master clock down to the 6.144 MHz pixel rate
	localparam int CLK_DIV_DEF = 8;

	// Horizontal blank, both ends inclusive
	localparam int HBLANK_FIRST = 138;
	localparam int HBLANK_LAST  = 268;
	// Vertical blank wraps through line 0
	localparam int VBLANK_START = 240;
	localparam int VBLANK_END   = 16;

	// Sync windows, start inclusive and end exclusive
	localparam int HSYNC_START = 176;
	localparam int HSYNC_END   = 208;
	localparam int VSYNC_START = 244;
	localparam int VSYNC_END   = 252;

	// Beam coordinates
	typedef logic [8:0] hcount_t;
	typedef logic [7:0] vcount_t;
	// Character RAM address, tile row in [9:5] and tile column in [4:0]
	typedef logic [9:0] tile_addr_t;
	// Pixel offset inside an 8x8 tile
	typedef logic [2:0] fine_t;

endpackage

`default_nettype wire

//--- logic/tp84_regs_pkg.sv
`default_nettype none

package tp84_regs_pkg;

	// ==================================================
	// Video register port
	// ==================================================

	// Register select, stands in for the CPU latch addresses
	// Codes 4 to 7 decode to nothing
	typedef enum logic [2:0] {
		REG_XSCROLL = 3'd0,
		REG_YSCROLL = 3'd1,
		REG_FLIP    = 3'd2,
		REG_IRQ_EN  = 3'd3
	} reg_sel_e;

	// One data byte, the width of the MC6809 bus
	typedef logic [7:0] reg_data_t;

	// Bit positions inside the flip register
	// Bit 0 mirrors the screen left to right
	localparam int FLIP_H_BIT = 0;
	// Bit 1 mirrors it top to bottom
	localparam int FLIP_V_BIT = 1;

endpackage

`default_nettype wire

//--- logic/beam_counter.sv
`timescale 1ns/1ps
`default_nettype none

module beam_counter #(
	parameter int H_TOTAL = tp84_timing_pkg::H_TOTAL_DEF,
	parameter int V_TOTAL = tp84_timing_pkg::V_TOTAL_DEF,
	parameter int CLK_DIV = tp84_timing_pkg::CLK_DIV_DEF
) (
	input  logic                     clk_49m,
	input  logic                     reset_i,
	output tp84_timing_pkg::hcount_t h_o,
	output tp84_timing_pkg::vcount_t v_o,
	output logic                     hblank_o,
	output logic                     vblank_o,
	output logic                     hsync_o,
	output logic                     vsync_o
);

	// Divider width, kept at one bit for a divide by one
	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	// Line counter is wider than v_o when V_TOTAL exceeds 256
	localparam int LINE_W = $clog2(V_TOTAL);

	logic [DIV_W-1:0]         div_cnt;
	logic                     pix_en;
	logic [LINE_W-1:0]        line_cnt;
	tp84_timing_pkg::hcount_t h_next;
	logic [LINE_W-1:0]        line_next;

	// ==================================================
	// Pixel enable
	// ==================================================

	// One pulse every CLK_DIV master clocks
	// Registered, so the counters step in the cycle after the pulse is seen
	always_ff @(posedge clk_49m) begin
		if (reset_i) begin
			div_cnt <= '0;
			pix_en <= 1'b0;
		end else begin
			if (int'(div_cnt) == CLK_DIV - 1) begin
				div_cnt <= '0;
				pix_en <= 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
				pix_en <= 1'b0;
			end
		end
	end

	// ==================================================
	// Beam counters
	// ==================================================

	// Next beam position, held between enables
	always_comb begin
		h_next = h_o;
		line_next = line_cnt;
		if (pix_en) begin
			if (int'(h_o) == H_TOTAL - 1) begin
				// End of line, the vertical count moves on
				h_next = '0;
				if (int'(line_cnt) == V_TOTAL - 1) begin
					line_next = '0;
				end else begin
					line_next = line_cnt + 1'b1;
				end
			end else begin
				h_next = h_o + 1'b1;
			end
		end
	end

	// Flags come from the next position so they change together with h_o and v_o
	// Line 0 sits inside vertical blank, hence the set reset value
	always_ff @(posedge clk_49m) begin
		if (reset_i) begin
			h_o <= '0;
			line_cnt <= '0;
			hblank_o <= 1'b0;
			vblank_o <= 1'b1;
			hsync_o <= 1'b0;
			vsync_o <= 1'b0;
		end else begin
			h_o <= h_next;
			line_cnt <= line_next;
			hblank_o <= (h_next >= tp84_timing_pkg::HBLANK_FIRST) &&
				(h_next <= tp84_timing_pkg::HBLANK_LAST);
			// Blank wraps around the end of the frame
			vblank_o <= (line_next >= tp84_timing_pkg::VBLANK_START) ||
				(line_next < tp84_timing_pkg::VBLANK_END);
			hsync_o <= (h_next >= tp84_timing_pkg::HSYNC_START) &&
				(h_next < tp84_timing_pkg::HSYNC_END);
			vsync_o <= (line_next >= tp84_timing_pkg::VSYNC_START) &&
				(line_next < tp84_timing_pkg::VSYNC_END);
		end
	end

	// Only the low eight line bits leave the block, like the 082 V outputs
	// Lines 256 and up read back as 0 and up, all inside blank
	assign v_o = line_cnt[7:0];

endmodule

`default_nettype wire

//--- logic/scroll_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scroll_regs (
	input  logic                       clk_49m,
	input  logic                       reset_i,
	input  logic                       wr_i,
	input  tp84_regs_pkg::reg_sel_e    reg_sel_i,
	input  tp84_regs_pkg::reg_data_t   wr_data_i,
	input  logic                       vblank_i,
	output tp84_regs_pkg::reg_data_t   xscroll_o,
	output tp84_regs_pkg::reg_data_t   yscroll_o,
	output logic                       hflip_o,
	output logic                       vflip_o,
	output logic                       irq_o
);

	logic irq_en;
	logic vblank_d;
	logic vblank_rise;
	logic irq_clr_wr;

	// ==================================================
	// Register writes
	// ==================================================

	// Single-cycle strobe, every write lands on the next edge
	always_ff @(posedge clk_49m) begin
		if (reset_i) begin
			xscroll_o <= '0;
			yscroll_o <= '0;
			hflip_o <= 1'b0;
			vflip_o <= 1'b0;
			irq_en <= 1'b0;
		end else if (wr_i) begin
			case (reg_sel_i)
				tp84_regs_pkg::REG_XSCROLL: xscroll_o <= wr_data_i;
				tp84_regs_pkg::REG_YSCROLL: yscroll_o <= wr_data_i;
				tp84_regs_pkg::REG_FLIP: begin
					hflip_o <= wr_data_i[tp84_regs_pkg::FLIP_H_BIT];
					vflip_o <= wr_data_i[tp84_regs_pkg::FLIP_V_BIT];
				end
				// Enable lives in data bit 0, same as the original latch
				tp84_regs_pkg::REG_IRQ_EN: irq_en <= wr_data_i[0];
				// Unused select codes
				default: ;
			endcase
		end
	end

	// ==================================================
	// VBlank interrupt
	// ==================================================

	// Edge detect on vertical blank
	assign vblank_rise = vblank_i & ~vblank_d;

	// A zero written to the enable drops the flag on the same edge as the write
	assign irq_clr_wr = wr_i && (reg_sel_i == tp84_regs_pkg::REG_IRQ_EN) && !wr_data_i[0];

	// Delay starts high since blank is active out of reset
	always_ff @(posedge clk_49m) begin
		if (reset_i) begin
			vblank_d <= 1'b1;
		end else begin
			vblank_d <= vblank_i;
		end
	end

	// Flag is held low for as long as the enable stays 0
	// Writing 1 alone does not set it, it waits for the next blank edge
	always_ff @(posedge clk_49m) begin
		if (reset_i) begin
			irq_o <= 1'b0;
		end else if (irq_clr_wr || !irq_en) begin
			irq_o <= 1'b0;
		end else if (vblank_rise) begin
			irq_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/bg_address_gen.sv
`timescale 1ns/1ps
`default_nettype none

module bg_address_gen (
	input  tp84_timing_pkg::hcount_t    h_i,
	input  tp84_timing_pkg::vcount_t    v_i,
	input  tp84_regs_pkg::reg_data_t    xscroll_i,
	input  tp84_regs_pkg::reg_data_t    yscroll_i,
	input  logic                        hflip_i,
	input  logic                        vflip_i,
	output tp84_timing_pkg::tile_addr_t tile_addr_o,
	output tp84_timing_pkg::fine_t      fine_x_o,
	output tp84_timing_pkg::fine_t      fine_y_o
);

	// Beam position after the flip XOR
	logic [7:0] h_flip;
	logic [7:0] v_flip;
	// Scrolled playfield position, wraps at 256
	logic [7:0] h_sum;
	logic [7:0] v_sum;

	// ==================================================
	// Flip
	// ==================================================

	// Inverting every bit mirrors the count, 0 becomes 255
	// 256H does not take part, the playfield is 256 pixels wide
	assign h_flip = h_i[7:0] ^ {8{hflip_i}};
	assign v_flip = v_i ^ {8{vflip_i}};

	// ==================================================
	// Scroll
	// ==================================================

	// Carry out of bit 7 is dropped so the playfield wraps
	assign h_sum = h_flip + xscroll_i;
	assign v_sum = v_flip + yscroll_i;

	// ==================================================
	// Tile address and fine offsets
	// ==================================================

	// 32 x 32 tile map, row on top
	assign tile_addr_o = {v_sum[7:3], h_sum[7:3]};

	// Pixel and line inside the tile, for the character ROM address
	assign fine_x_o = h_sum[2:0];
	assign fine_y_o = v_sum[2:0];

endmodule

`default_nettype wire

//--- logic/tp84_video_top.sv
`timescale 1ns/1ps
`default_nettype none

module tp84_video_top #(
	parameter int H_TOTAL = tp84_timing_pkg::H_TOTAL_DEF,
	parameter int V_TOTAL = tp84_timing_pkg::V_TOTAL_DEF,
	parameter int CLK_DIV = tp84_timing_pkg::CLK_DIV_DEF
) (
	input  logic                        clk_49m,
	input  logic                        reset_i,
	// Register write port
	input  logic                        wr_i,
	input  tp84_regs_pkg::reg_sel_e     reg_sel_i,
	input  tp84_regs_pkg::reg_data_t    wr_data_i,
	// Beam position and video timing
	output tp84_timing_pkg::hcount_t    h_o,
	output tp84_timing_pkg::vcount_t    v_o,
	output logic                        hblank_o,
	output logic                        vblank_o,
	output logic                        hsync_o,
	output logic                        vsync_o,
	// VBlank interrupt to the CPU
	output logic                        irq_o,
	// Background fetch address
	output tp84_timing_pkg::tile_addr_t tile_addr_o,
	output tp84_timing_pkg::fine_t      fine_x_o,
	output tp84_timing_pkg::fine_t      fine_y_o
);

	// Register values into the address generator
	tp84_regs_pkg::reg_data_t xscroll;
	tp84_regs_pkg::reg_data_t yscroll;
	logic                     hflip;
	logic                     vflip;

	// ==================================================
	// Video timing
	// ==================================================

	beam_counter #(
		.H_TOTAL(H_TOTAL),
		.V_TOTAL(V_TOTAL),
		.CLK_DIV(CLK_DIV)
	) beam_counter_i (
		.clk_49m(clk_49m),
		.reset_i(reset_i),
		.h_o(h_o),
		.v_o(v_o),
		.hblank_o(hblank_o),
		.vblank_o(vblank_o),
		.hsync_o(hsync_o),
		.vsync_o(vsync_o)
	);

	// Scroll, flip and interrupt latches
	scroll_regs scroll_regs_i (
		.clk_49m(clk_49m),
		.reset_i(reset_i),
		.wr_i(wr_i),
		.reg_sel_i(reg_sel_i),
		.wr_data_i(wr_data_i),
		.vblank_i(vblank_o),
		.xscroll_o(xscroll),
		.yscroll_o(yscroll),
		.hflip_o(hflip),
		.vflip_o(vflip),
		.irq_o(irq_o)
	);

	// Background address, no added latency
	bg_address_gen bg_address_gen_i (
		.h_i(h_o),
		.v_i(v_o),
		.xscroll_i(xscroll),
		.yscroll_i(yscroll),
		.hflip_i(hflip),
		.vflip_i(vflip),
		.tile_addr_o(tile_addr_o),
		.fine_x_o(fine_x_o),
		.fine_y_o(fine_y_o)
	);

endmodule

`default_nettype wire

//--- tests/tb_tp84_checks.svh
`ifndef TB_TP84_CHECKS_SVH
`define TB_TP84_CHECKS_SVH

// ==================================================
// Random source
// ==================================================

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, shifting right
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic [31:0] nxt;
	nxt = state >> 1;
	if (state[0]) begin
		nxt = nxt ^ 32'h8020_0003;
	end
	return nxt;
endfunction

// One LFSR step per bit taken, low state bit feeds the result
task automatic draw_bits(input int width, output int unsigned value);
	value = 0;
	for (int i = 0; i < width; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		value = {value[30:0], lfsr_state[0]};
	end
endtask

// ==================================================
// Background address reference
// ==================================================

// Result packs {tile row, tile column, fine x, fine y}
function automatic logic [15:0] bg_reference(
	input tp84_timing_pkg::hcount_t h,
	input tp84_timing_pkg::vcount_t v,
	input tp84_regs_pkg::reg_data_t xs,
	input tp84_regs_pkg::reg_data_t ys,
	input logic                     hf,
	input logic                     vf
);
	int px;
	int py;
	logic [7:0] sx;
	logic [7:0] sy;
	// Flipped screen counts back from the far edge, 256H ignored
	px = hf ? 255 - int'(h[7:0]) : int'(h[7:0]);
	py = vf ? 255 - int'(v) : int'(v);
	// 256 x 256 playfield wraps around
	px = (px + int'(xs)) % 256;
	py = (py + int'(ys)) % 256;
	sx = px[7:0];
	sy = py[7:0];
	return {sy[7:3], sx[7:3], sx[2:0], sy[2:0]};
endfunction

// ==================================================
// Typed compares
// ==================================================

task automatic compare_tile(input string name, input tp84_timing_pkg::tile_addr_t expected,
	input tp84_timing_pkg::tile_addr_t actual);
	if (actual !== expected) begin
		$display("FAIL %s: expected 0x%03h, actual 0x%03h", name, expected, actual);
		stop_with_failure();
	end
endtask

task automatic compare_fine(input string name, input tp84_timing_pkg::fine_t expected,
	input tp84_timing_pkg::fine_t actual);
	if (actual !== expected) begin
		$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
		stop_with_failure();
	end
endtask

task automatic compare_h(input string name, input tp84_timing_pkg::hcount_t expected,
	input tp84_timing_pkg::hcount_t actual);
	if (actual !== expected) begin
		$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
		stop_with_failure();
	end
endtask

task automatic compare_v(input string name, input tp84_timing_pkg::vcount_t expected,
	input tp84_timing_pkg::vcount_t actual);
	if (actual !== expected) begin
		$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
		stop_with_failure();
	end
endtask

task automatic compare_flag(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("FAIL %s: expected %b, actual %b", name, expected, actual);
		stop_with_failure();
	end
endtask

`endif

//--- tests/tb_tp84_video.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tp84_video;

	localparam int H_TOTAL = tp84_timing_pkg::H_TOTAL_DEF;
	localparam int V_TOTAL = tp84_timing_pkg::V_TOTAL_DEF;
	localparam int CLK_DIV = tp84_timing_pkg::CLK_DIV_DEF;
	// Two full frames of master clocks plus margin
	localparam int CYCLE_LIMIT = H_TOTAL * V_TOTAL * CLK_DIV * 2 + 2000;
	localparam int NUM_WRITES = 300;

	logic                        clk_49m;
	logic                        reset_i;
	logic                        wr_i;
	tp84_regs_pkg::reg_sel_e     reg_sel_i;
	tp84_regs_pkg::reg_data_t    wr_data_i;
	tp84_timing_pkg::hcount_t    h_o;
	tp84_timing_pkg::vcount_t    v_o;
	logic                        hblank_o;
	logic                        vblank_o;
	logic                        hsync_o;
	logic                        vsync_o;
	logic                        irq_o;
	tp84_timing_pkg::tile_addr_t tile_addr_o;
	tp84_timing_pkg::fine_t      fine_x_o;
	tp84_timing_pkg::fine_t      fine_y_o;

	logic [31:0] lfsr_state = 32'd73227;
	int          cycle_cnt = 0;

	// Checker model
	tp84_timing_pkg::hcount_t h_prev;
	int                       h_step_exp;
	int                       line_m;
	int                       gap;
	logic                     h_started;
	logic                     vblank_prev;
	tp84_regs_pkg::reg_data_t xs_m;
	tp84_regs_pkg::reg_data_t ys_m;
	logic                     hf_m;
	logic                     vf_m;
	logic                     en_m;
	logic                     irq_exp;
	logic [15:0]              bg_exp;

	task automatic stop_with_failure();
		$display("Checks failed");
		$fatal(1);
	endtask

	`include "tb_tp84_checks.svh"

	tp84_video_top #(
		.H_TOTAL(H_TOTAL),
		.V_TOTAL(V_TOTAL),
		.CLK_DIV(CLK_DIV)
	) dut_i (
		.clk_49m(clk_49m),
		.reset_i(reset_i),
		.wr_i(wr_i),
		.reg_sel_i(reg_sel_i),
		.wr_data_i(wr_data_i),
		.h_o(h_o),
		.v_o(v_o),
		.hblank_o(hblank_o),
		.vblank_o(vblank_o),
		.hsync_o(hsync_o),
		.vsync_o(vsync_o),
		.irq_o(irq_o),
		.tile_addr_o(tile_addr_o),
		.fine_x_o(fine_x_o),
		.fine_y_o(fine_y_o)
	);

	// 100 ns period
	initial begin
		clk_49m = 1'b0;
		forever #50 clk_49m = ~clk_49m;
	end

	// Run limit
	always @(posedge clk_49m) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			stop_with_failure();
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================

	// Strobe lasts one cycle, register holds the value from the next edge
	task automatic write_reg(input tp84_regs_pkg::reg_sel_e sel,
		input tp84_regs_pkg::reg_data_t data);
		@(posedge clk_49m);
		wr_i <= 1'b1;
		reg_sel_i <= sel;
		wr_data_i <= data;
		@(posedge clk_49m);
		wr_i <= 1'b0;
	endtask

	// Returns at the falling edge where vblank_o is first seen high
	task automatic wait_vblank_rise();
		logic last;
		@(negedge clk_49m);
		last = vblank_o;
		@(negedge clk_49m);
		while (!(vblank_o && !last)) begin
			last = vblank_o;
			@(negedge clk_49m);
		end
	endtask

	initial begin
		int unsigned kind;
		int unsigned data;
		int unsigned gap_len;
		int unsigned extra;
		logic [2:0] code;
		reset_i = 1'b1;
		wr_i = 1'b0;
		reg_sel_i = tp84_regs_pkg::REG_XSCROLL;
		wr_data_i = '0;
		repeat (3) @(posedge clk_49m);
		reset_i <= 1'b0;

		// Reset state
		@(negedge clk_49m);
		compare_h("reset h_o", 9'd0, h_o);
		compare_v("reset v_o", 8'd0, v_o);
		compare_flag("reset irq_o", 1'b0, irq_o);
		compare_flag("reset hsync_o", 1'b0, hsync_o);
		compare_flag("reset vsync_o", 1'b0, vsync_o);
		compare_flag("reset vblank_o", 1'b1, vblank_o);

		write_reg(tp84_regs_pkg::REG_IRQ_EN, 8'h01);

		// Random scroll and flip writes, a quarter go to unused codes
		for (int n = 0; n < NUM_WRITES; n++) begin
			draw_bits(2, kind);
			draw_bits(8, data);
			draw_bits(11, gap_len);
			case (kind)
				0: code = 3'd0;
				1: code = 3'd1;
				2: code = 3'd2;
				default: begin
					draw_bits(2, extra);
					code = 3'd4 + 3'(extra[1:0]);
				end
			endcase
			write_reg(tp84_regs_pkg::reg_sel_e'(code), data[7:0]);
			repeat (gap_len) @(posedge clk_49m);
		end

		// Interrupt raised one cycle after the blank edge
		wait_vblank_rise();
		@(negedge clk_49m);
		compare_flag("irq after vblank rise", 1'b1, irq_o);
		write_reg(tp84_regs_pkg::REG_IRQ_EN, 8'h00);
		@(negedge clk_49m);
		compare_flag("irq cleared by enable write", 1'b0, irq_o);
		// Masked through the next frame
		wait_vblank_rise();
		@(negedge clk_49m);
		compare_flag("irq masked at vblank rise", 1'b0, irq_o);
		// Enable alone does not raise it
		write_reg(tp84_regs_pkg::REG_IRQ_EN, 8'h01);
		repeat (8) @(negedge clk_49m);
		compare_flag("irq after enable write", 1'b0, irq_o);

		$display("All checks passed");
		$finish;
	end

	// ==================================================
	// Checker
	// ==================================================

	// Samples at the falling edge, halfway between input changes
	always @(negedge clk_49m) begin
		if (reset_i) begin
			h_prev = '0;
			line_m = 0;
			gap = 0;
			h_started = 1'b0;
			vblank_prev = 1'b1;
			xs_m = '0;
			ys_m = '0;
			hf_m = 1'b0;
			vf_m = 1'b0;
			en_m = 1'b0;
			irq_exp = 1'b0;
		end else begin
			gap = gap + 1;
			if (h_o !== h_prev) begin
				h_step_exp = (int'(h_prev) + 1) % H_TOTAL;
				compare_h("beam h step", h_step_exp[8:0], h_o);
				if (h_started && gap != CLK_DIV) begin
					$display("Error: h_o stepped %0d cycles after its last step, not %0d",
						gap, CLK_DIV);
					stop_with_failure();
				end
				// Line moves on with the wrap to 0
				if (h_o == 0) begin
					line_m = (line_m + 1) % V_TOTAL;
				end
				h_started = 1'b1;
				gap = 0;
				h_prev = h_o;
			end else if (h_started && gap > CLK_DIV) begin
				$display("Error: h_o held for more than %0d cycles", CLK_DIV);
				stop_with_failure();
			end
			compare_v("beam v step", line_m[7:0], v_o);

			// Blank and sync windows of the current position
			compare_flag("hblank window", (h_o >= tp84_timing_pkg::HBLANK_FIRST) &&
				(h_o <= tp84_timing_pkg::HBLANK_LAST), hblank_o);
			compare_flag("vblank window", (v_o >= tp84_timing_pkg::VBLANK_START) ||
				(v_o < tp84_timing_pkg::VBLANK_END), vblank_o);
			compare_flag("hsync window", (h_o >= tp84_timing_pkg::HSYNC_START) &&
				(h_o < tp84_timing_pkg::HSYNC_END), hsync_o);
			compare_flag("vsync window", (v_o >= tp84_timing_pkg::VSYNC_START) &&
				(v_o < tp84_timing_pkg::VSYNC_END), vsync_o);

			bg_exp = bg_reference(h_o, v_o, xs_m, ys_m, hf_m, vf_m);
			compare_tile("scrolled tile address", bg_exp[15:6], tile_addr_o);
			compare_fine("scrolled fine x", bg_exp[5:3], fine_x_o);
			compare_fine("scrolled fine y", bg_exp[2:0], fine_y_o);
			compare_flag("vblank interrupt", irq_exp, irq_o);

			// Interrupt for the next cycle, enable value before this write
			if ((wr_i && reg_sel_i == tp84_regs_pkg::REG_IRQ_EN && !wr_data_i[0]) || !en_m) begin
				irq_exp = 1'b0;
			end else if (vblank_o && !vblank_prev) begin
				irq_exp = 1'b1;
			end
			vblank_prev = vblank_o;

			// Strobe seen now takes effect from the next cycle
			if (wr_i) begin
				case (reg_sel_i)
					tp84_regs_pkg::REG_XSCROLL: xs_m = wr_data_i;
					tp84_regs_pkg::REG_YSCROLL: ys_m = wr_data_i;
					tp84_regs_pkg::REG_FLIP: begin
						hf_m = wr_data_i[tp84_regs_pkg::FLIP_H_BIT];
						vf_m = wr_data_i[tp84_regs_pkg::FLIP_V_BIT];
					end
					tp84_regs_pkg::REG_IRQ_EN: en_m = wr_data_i[0];
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- tp84_video.f
logic/tp84_timing_pkg.sv
logic/tp84_regs_pkg.sv
logic/beam_counter.sv
logic/scroll_regs.sv
logic/bg_address_gen.sv
logic/tp84_video_top.sv
+incdir+tests
tests/tb_tp84_video.sv
